// File: sim.f
src/pad_pkg.sv
src/pad_input.sv
src/pinmux_core.sv
src/pad_output.sv
src/pad_subsys_top.sv
testbench/pad_model_checker.sv
testbench/tb_pad_subsys.sv

// File: src/pad_input.sv
/*
 * Pad input stage: masks unwired pads, applies the per-pad input
 * inversion and brings the values into the clock domain with two flops
 */
`default_nettype none

module pad_input #(
  // Pads physically wired on the board
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioIn = '1
) (
  input  logic                                          clk_main_i,
  input  logic                                          rst_n_i,
  input  logic [pad_pkg::NMioPads-1:0]                  pad_in_i,
  input  logic [pad_pkg::NMioPads-1:0][pad_pkg::AttrDw-1:0] attr_i,
  output logic [pad_pkg::NMioPads-1:0]                  sync_o
);

  import pad_pkg::*;

  logic [NMioPads-1:0] in_gated;
  logic [NMioPads-1:0] sync_q1;
  logic [NMioPads-1:0] sync_q2;

  //////////////////////////////////////////////////////////////////////
  // Masking and inversion
  //////////////////////////////////////////////////////////////////////

  // Unwired pads read 0 regardless of the invert bit
  always_comb begin
    for (int k = 0; k < NMioPads; k++) begin
      if (ConnectMioIn[k]) begin
        in_gated[k] = pad_in_i[k] ^ attr_i[k][AttrInv];
      end else begin
        in_gated[k] = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Two stage synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= in_gated;
      sync_q2 <= sync_q1;
    end
  end

  assign sync_o = sync_q2;

endmodule : pad_input

`default_nettype wire

// File: src/pad_output.sv
/*
 * Pad output stage: applies invert and open drain per pad, holds
 * unwired pads released and registers the drive towards the board
 */
`default_nettype none

module pad_output #(
  // Pads physically wired on the board
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioOut = '1
) (
  input  logic                                              clk_main_i,
  input  logic                                              rst_n_i,
  input  logic [pad_pkg::NMioPads-1:0]                      out_i,
  input  logic [pad_pkg::NMioPads-1:0]                      oe_i,
  input  logic [pad_pkg::NMioPads-1:0][pad_pkg::AttrDw-1:0] attr_i,
  output logic [pad_pkg::NMioPads-1:0]                      pad_out_o,
  output logic [pad_pkg::NMioPads-1:0]                      pad_oe_o
);

  import pad_pkg::*;

  logic [NMioPads-1:0] out_inv;
  logic [NMioPads-1:0] out_d;
  logic [NMioPads-1:0] oe_d;
  logic [NMioPads-1:0] out_q;
  logic [NMioPads-1:0] oe_q;

  //////////////////////////////////////////////////////////////////////
  // Attribute handling
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < NMioPads; k++) begin
      // Invert comes first, open drain works on the inverted value
      out_inv[k] = out_i[k] ^ attr_i[k][AttrInv];

      if (!ConnectMioOut[k]) begin
        // Tied off, never drives
        out_d[k] = 1'b0;
        oe_d[k]  = 1'b0;
      end else if (attr_i[k][AttrOd]) begin
        // A 1 releases the pad, a 0 pulls low when enabled
        out_d[k] = 1'b0;
        oe_d[k]  = out_inv[k] ? 1'b0 : oe_i[k];
      end else begin
        out_d[k] = out_inv[k];
        oe_d[k]  = oe_i[k];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drive registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      out_q <= out_d;
      oe_q  <= oe_d;
    end
  end

  assign pad_out_o = out_q;
  assign pad_oe_o  = oe_q;

endmodule : pad_output

`default_nettype wire

// File: src/pad_pkg.sv
/*
 * Pad subsystem package with pad counts, attribute bit positions and
 * the configuration opcode and output source encodings
 */
`default_nettype none

package pad_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pad geometry
  //////////////////////////////////////////////////////////////////////

  // Multiplexed pads coming in from the board
  parameter int NMioPads = 16;
  parameter int PadIdxW  = 4;

  // Per-pad attribute field
  parameter int AttrDw  = 2;
  parameter int AttrInv = 0;
  parameter int AttrOd  = 1;

  //////////////////////////////////////////////////////////////////////
  // Configuration port
  //////////////////////////////////////////////////////////////////////

  // Sel opcode packs the source index above the select field
  parameter int CfgDataW = 6;

  typedef enum logic [2:0] {
    OpNop     = 3'd0,
    OpSetOut  = 3'd1,
    OpSetOe   = 3'd2,
    OpSetSel  = 3'd3,
    OpSetAttr = 3'd4
  } cfg_op_e;

  // What a pad drives out
  typedef enum logic [1:0] {
    SelGpio    = 2'd0,
    SelPadLoop = 2'd1,
    SelTieLow  = 2'd2,
    SelTieHigh = 2'd3
  } mio_sel_e;

endpackage : pad_pkg

`default_nettype wire

// File: src/pad_subsys_top.sv
/*
 * Pad subsystem top: input stage, pin multiplexer core and output stage
 * for the sixteen multiplexed pads, with the board wiring as parameters
 */
`default_nettype none

module pad_subsys_top #(
  // Pads 11:0 wired for input, 9:0 for output, the rest tied off
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioIn  = 16'h0FFF,
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioOut = 16'h03FF
) (
  // Clock and reset
  input  logic                          clk_main_i,
  input  logic                          rst_n_i,

  // Board pads
  input  logic [pad_pkg::NMioPads-1:0]  pad_in_i,
  output logic [pad_pkg::NMioPads-1:0]  pad_out_o,
  output logic [pad_pkg::NMioPads-1:0]  pad_oe_o,

  // Configuration write port
  input  logic                          cfg_we_i,
  input  pad_pkg::cfg_op_e              cfg_op_i,
  input  logic [pad_pkg::PadIdxW-1:0]   cfg_idx_i,
  input  logic [pad_pkg::CfgDataW-1:0]  cfg_data_i,

  // GPIO input readback
  output logic [pad_pkg::NMioPads-1:0]  gpio_in_o
);

  import pad_pkg::*;

  logic [NMioPads-1:0]             sync_in;
  logic [NMioPads-1:0]             core_out;
  logic [NMioPads-1:0]             core_oe;
  logic [NMioPads-1:0][AttrDw-1:0] core_attr;

  //////////////////////////////////////////////////////////////////////
  // Input stage
  //////////////////////////////////////////////////////////////////////

  pad_input #(
    .ConnectMioIn ( ConnectMioIn )
  ) pad_input_i (
    .clk_main_i ( clk_main_i ),
    .rst_n_i    ( rst_n_i    ),
    .pad_in_i   ( pad_in_i   ),
    .attr_i     ( core_attr  ),
    .sync_o     ( sync_in    )
  );

  //////////////////////////////////////////////////////////////////////
  // Pin multiplexer
  //////////////////////////////////////////////////////////////////////

  pinmux_core pinmux_core_i (
    .clk_main_i ( clk_main_i ),
    .rst_n_i    ( rst_n_i    ),
    .cfg_we_i   ( cfg_we_i   ),
    .cfg_op_i   ( cfg_op_i   ),
    .cfg_idx_i  ( cfg_idx_i  ),
    .cfg_data_i ( cfg_data_i ),
    .sync_i     ( sync_in    ),
    .out_o      ( core_out   ),
    .oe_o       ( core_oe    ),
    .attr_o     ( core_attr  ),
    .gpio_in_o  ( gpio_in_o  )
  );

  //////////////////////////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////////////////////////

  pad_output #(
    .ConnectMioOut ( ConnectMioOut )
  ) pad_output_i (
    .clk_main_i ( clk_main_i ),
    .rst_n_i    ( rst_n_i    ),
    .out_i      ( core_out   ),
    .oe_i       ( core_oe    ),
    .attr_i     ( core_attr  ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

endmodule : pad_subsys_top

`default_nettype wire

// File: src/pinmux_core.sv
/*
 * Pin multiplexer core: holds the per-pad configuration registers
 * written over the strobe port and picks each pad's output source
 */
`default_nettype none

module pinmux_core (
  input  logic                                              clk_main_i,
  input  logic                                              rst_n_i,

  // Configuration write port
  input  logic                                              cfg_we_i,
  input  pad_pkg::cfg_op_e                                  cfg_op_i,
  input  logic [pad_pkg::PadIdxW-1:0]                       cfg_idx_i,
  input  logic [pad_pkg::CfgDataW-1:0]                      cfg_data_i,

  // Synchronized pad inputs
  input  logic [pad_pkg::NMioPads-1:0]                      sync_i,

  // Towards the output stage
  output logic [pad_pkg::NMioPads-1:0]                      out_o,
  output logic [pad_pkg::NMioPads-1:0]                      oe_o,
  output logic [pad_pkg::NMioPads-1:0][pad_pkg::AttrDw-1:0] attr_o,

  // GPIO input readback
  output logic [pad_pkg::NMioPads-1:0]                      gpio_in_o
);

  import pad_pkg::*;

  // Per-pad configuration state
  logic [NMioPads-1:0]             gpio_out_q;
  logic [NMioPads-1:0]             gpio_oe_q;
  mio_sel_e                        sel_q     [NMioPads];
  logic [PadIdxW-1:0]              src_idx_q [NMioPads];
  logic [NMioPads-1:0][AttrDw-1:0] attr_q;

  // Fields unpacked from the write data
  logic               cfg_bit;
  mio_sel_e           cfg_sel;
  logic [PadIdxW-1:0] cfg_src_idx;
  logic [AttrDw-1:0]  cfg_attr;

  //////////////////////////////////////////////////////////////////////
  // Write data fields
  //////////////////////////////////////////////////////////////////////

  assign cfg_bit     = cfg_data_i[0];
  assign cfg_sel     = mio_sel_e'(cfg_data_i[1:0]);
  assign cfg_src_idx = cfg_data_i[CfgDataW-1:2];
  assign cfg_attr    = cfg_data_i[AttrDw-1:0];

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////

  // Writes land on the same edge that samples the strobe
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      attr_q     <= '0;
      for (int k = 0; k < NMioPads; k++) begin
        sel_q[k]     <= SelGpio;
        src_idx_q[k] <= '0;
      end
    end else if (cfg_we_i) begin
      case (cfg_op_i)
        OpSetOut: begin
          gpio_out_q[cfg_idx_i] <= cfg_bit;
        end
        OpSetOe: begin
          gpio_oe_q[cfg_idx_i] <= cfg_bit;
        end
        OpSetSel: begin
          sel_q[cfg_idx_i]     <= cfg_sel;
          src_idx_q[cfg_idx_i] <= cfg_src_idx;
        end
        OpSetAttr: begin
          attr_q[cfg_idx_i] <= cfg_attr;
        end
        OpNop: begin
          // Nothing to update
        end
        default: begin
          // Unused opcodes are ignored
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output source select
  //////////////////////////////////////////////////////////////////////

  // Loopback takes the already synchronized value of the source pad
  always_comb begin
    for (int k = 0; k < NMioPads; k++) begin
      case (sel_q[k])
        SelGpio: begin
          out_o[k] = gpio_out_q[k];
        end
        SelPadLoop: begin
          out_o[k] = sync_i[src_idx_q[k]];
        end
        SelTieLow: begin
          out_o[k] = 1'b0;
        end
        SelTieHigh: begin
          out_o[k] = 1'b1;
        end
        default: begin
          out_o[k] = 1'b0;
        end
      endcase
    end
  end

  // Enable always comes from the register, independent of the source
  assign oe_o   = gpio_oe_q;
  assign attr_o = attr_q;

  // Readback of the synchronized inputs
  assign gpio_in_o = sync_i;

endmodule : pinmux_core

`default_nettype wire

// File: testbench/pad_model_checker.sv
/*
 * Pad subsystem checker: reference model of the configuration registers
 * and pad pipeline, compared against the DUT on every rising edge
 */
`default_nettype none

module pad_model_checker #(
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioIn  = '1,
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMioOut = '1
) (
  input  logic                          clk_main_i,
  input  logic                          rst_n_i,
  input  logic [pad_pkg::NMioPads-1:0]  pad_in_i,
  input  logic                          cfg_we_i,
  input  pad_pkg::cfg_op_e              cfg_op_i,
  input  logic [pad_pkg::PadIdxW-1:0]   cfg_idx_i,
  input  logic [pad_pkg::CfgDataW-1:0]  cfg_data_i,
  input  logic [pad_pkg::NMioPads-1:0]  pad_out_i,
  input  logic [pad_pkg::NMioPads-1:0]  pad_oe_i,
  input  logic [pad_pkg::NMioPads-1:0]  gpio_in_i,
  output int                            err_count_o,
  output int                            check_count_o
);

  import pad_pkg::*;

  // Model of the configuration registers
  logic [NMioPads-1:0] m_gpio_out;
  logic [NMioPads-1:0] m_gpio_oe;
  mio_sel_e            m_sel  [NMioPads];
  logic [PadIdxW-1:0]  m_src  [NMioPads];
  logic [AttrDw-1:0]   m_attr [NMioPads];

  // Input delay line and registered pad drive
  logic [NMioPads-1:0] m_sync1;
  logic [NMioPads-1:0] m_sync2;
  logic [NMioPads-1:0] m_pad_out;
  logic [NMioPads-1:0] m_pad_oe;

  int   errors     = 0;
  int   checks     = 0;

  assign err_count_o   = errors;
  assign check_count_o = checks;

  task automatic compare_vec(input string name, input logic [NMioPads-1:0] exp,
                             input logic [NMioPads-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic reset_model();
    m_gpio_out = '0;
    m_gpio_oe  = '0;
    m_sync1    = '0;
    m_sync2    = '0;
    m_pad_out  = '0;
    m_pad_oe   = '0;
    for (int k = 0; k < NMioPads; k++) begin
      m_sel[k]  = SelGpio;
      m_src[k]  = '0;
      m_attr[k] = '0;
    end
  endtask

  task automatic apply_write();
    case (cfg_op_i)
      OpSetOut:  m_gpio_out[cfg_idx_i] = cfg_data_i[0];
      OpSetOe:   m_gpio_oe[cfg_idx_i]  = cfg_data_i[0];
      OpSetSel: begin
        m_sel[cfg_idx_i] = mio_sel_e'(cfg_data_i[1:0]);
        m_src[cfg_idx_i] = cfg_data_i[5:2];
      end
      OpSetAttr: m_attr[cfg_idx_i] = cfg_data_i[1:0];
      default: begin
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare, then advance the model by one edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_main_i) begin : model_step
    logic [NMioPads-1:0] in_gated;
    logic [NMioPads-1:0] nxt_out;
    logic [NMioPads-1:0] nxt_oe;
    logic                src_val;
    logic                drv_val;
    if (!rst_n_i) begin
      reset_model();
    end else begin
      compare_vec("pad_out_o", m_pad_out, pad_out_i);
      compare_vec("pad_oe_o", m_pad_oe, pad_oe_i);
      compare_vec("gpio_in_o", m_sync2, gpio_in_i);
      // Unwired pads never drive and always read 0
      compare_vec("pad_oe_o unwired", '0, pad_oe_i & ~ConnectMioOut);
      compare_vec("pad_out_o unwired", '0, pad_out_i & ~ConnectMioOut);
      compare_vec("gpio_in_o unwired", '0, gpio_in_i & ~ConnectMioIn);
      for (int k = 0; k < NMioPads; k++) begin
        in_gated[k] = ConnectMioIn[k] ? (pad_in_i[k] ^ m_attr[k][AttrInv]) : 1'b0;
        case (m_sel[k])
          SelGpio:    src_val = m_gpio_out[k];
          SelPadLoop: src_val = m_sync2[m_src[k]];
          SelTieLow:  src_val = 1'b0;
          default:    src_val = 1'b1;
        endcase
        drv_val = src_val ^ m_attr[k][AttrInv];
        if (!ConnectMioOut[k]) begin
          nxt_out[k] = 1'b0;
          nxt_oe[k]  = 1'b0;
        end else if (m_attr[k][AttrOd]) begin
          // Released on a 1
          nxt_out[k] = 1'b0;
          nxt_oe[k]  = drv_val ? 1'b0 : m_gpio_oe[k];
        end else begin
          nxt_out[k] = drv_val;
          nxt_oe[k]  = m_gpio_oe[k];
        end
      end
      m_pad_out = nxt_out;
      m_pad_oe  = nxt_oe;
      m_sync2   = m_sync1;
      m_sync1   = in_gated;
      if (cfg_we_i) begin
        apply_write();
      end
    end
  end

endmodule : pad_model_checker

`default_nettype wire

// File: testbench/tb_pad_subsys.sv
/*
 * Pad subsystem testbench: clock, reset, seeded random configuration
 * writes and pad inputs per test, with a watchdog
 */
`default_nettype none

module tb_pad_subsys;

  import pad_pkg::*;

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 4;
  localparam int NTests      = 6;
  localparam int TestCycles  = 150;
  localparam int DrainCycles = 4;
  localparam int TotalCycles = ResetCycles + NTests * (TestCycles + DrainCycles) + 2;

  localparam logic [NMioPads-1:0] ConnectIn  = 16'h0FFF;
  localparam logic [NMioPads-1:0] ConnectOut = 16'h03FF;

  logic                clk_main;
  logic                rst_n;
  logic [NMioPads-1:0] pad_in;
  logic                cfg_we;
  cfg_op_e             cfg_op;
  logic [PadIdxW-1:0]  cfg_idx;
  logic [CfgDataW-1:0] cfg_data;
  logic [NMioPads-1:0] pad_out;
  logic [NMioPads-1:0] pad_oe;
  logic [NMioPads-1:0] gpio_in;
  int                  err_count;
  int                  check_count;

  string test_names [NTests] = '{"reset", "gpio drive", "attributes",
                                 "source select", "input path", "unwired pads"};

  pad_subsys_top #(
    .ConnectMioIn  ( ConnectIn  ),
    .ConnectMioOut ( ConnectOut )
  ) pad_subsys_top_i (
    .clk_main_i ( clk_main ),
    .rst_n_i    ( rst_n    ),
    .pad_in_i   ( pad_in   ),
    .pad_out_o  ( pad_out  ),
    .pad_oe_o   ( pad_oe   ),
    .cfg_we_i   ( cfg_we   ),
    .cfg_op_i   ( cfg_op   ),
    .cfg_idx_i  ( cfg_idx  ),
    .cfg_data_i ( cfg_data ),
    .gpio_in_o  ( gpio_in  )
  );

  pad_model_checker #(
    .ConnectMioIn  ( ConnectIn  ),
    .ConnectMioOut ( ConnectOut )
  ) model_checker_i (
    .clk_main_i    ( clk_main    ),
    .rst_n_i       ( rst_n       ),
    .pad_in_i      ( pad_in      ),
    .cfg_we_i      ( cfg_we      ),
    .cfg_op_i      ( cfg_op      ),
    .cfg_idx_i     ( cfg_idx     ),
    .cfg_data_i    ( cfg_data    ),
    .pad_out_i     ( pad_out     ),
    .pad_oe_i      ( pad_oe      ),
    .gpio_in_i     ( gpio_in     ),
    .err_count_o   ( err_count   ),
    .check_count_o ( check_count )
  );

  initial begin
    clk_main = 1'b0;
    forever #(ClkPeriod / 2) clk_main = ~clk_main;
  end

  // Opcode mix for each test
  function automatic cfg_op_e pick_op(input int mode);
    int r;
    r = $urandom_range(2);
    case (mode)
      2: return (r == 0) ? OpSetOe : OpSetOut;
      3: return (r == 0) ? OpSetOut : ((r == 1) ? OpSetOe : OpSetAttr);
      4: return (r == 0) ? OpSetOe : ((r == 1) ? OpSetOut : OpSetSel);
      5: return (r == 0) ? OpSetAttr : OpNop;
      default: return cfg_op_e'($urandom_range(4));
    endcase
  endfunction

  function automatic logic [PadIdxW-1:0] pick_idx(input int mode);
    if (mode == 2 || mode == 3) begin
      return PadIdxW'($urandom_range(9));
    end else if (mode == 6) begin
      return PadIdxW'($urandom_range(15, 10));
    end
    return PadIdxW'($urandom_range(15));
  endfunction

  // One test, then a few idle cycles so its effects settle
  task automatic run_test(input int mode);
    for (int c = 0; c < TestCycles; c++) begin
      @(negedge clk_main);
      pad_in = (mode == 1) ? '0 : NMioPads'($urandom);
      if (mode != 1 && $urandom_range(2) == 0) begin
        cfg_we   = 1'b1;
        cfg_op   = pick_op(mode);
        cfg_idx  = pick_idx(mode);
        cfg_data = CfgDataW'($urandom_range(63));
      end else begin
        cfg_we = 1'b0;
        cfg_op = OpNop;
      end
    end
    repeat (DrainCycles) begin
      @(negedge clk_main);
      cfg_we = 1'b0;
      cfg_op = OpNop;
    end
  endtask

  initial begin
    int seed_dummy;
    int errs_before;
    int tests_ok;
    rst_n       = 1'b0;
    pad_in      = '0;
    cfg_we      = 1'b0;
    cfg_op      = OpNop;
    cfg_idx     = '0;
    cfg_data    = '0;
    tests_ok    = 0;
    seed_dummy  = $urandom(5367);
    repeat (ResetCycles) @(posedge clk_main);
    @(negedge clk_main);
    rst_n = 1'b1;

    for (int t = 1; t <= NTests; t++) begin
      errs_before = err_count;
      run_test(t);
      if (err_count == errs_before) begin
        tests_ok++;
        $display("test %0d %-14s ok", t, test_names[t - 1]);
      end else begin
        $display("test %0d %-14s %0d errors", t, test_names[t - 1], err_count - errs_before);
      end
    end

    $display("Summary: %0d of %0d tests ok, %0d checks, %0d errors",
             tests_ok, NTests, check_count, err_count);
    if (err_count == 0 && tests_ok == NTests) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog at 1.5 times the full stimulus length
  initial begin
    #(TotalCycles * ClkPeriod * 3 / 2);
    $display("Watchdog timeout: stimulus did not complete in time");
    $display("Regression failed");
    $finish;
  end

endmodule : tb_pad_subsys

`default_nettype wire
